// File: accessAlign.sv
`timescale 1ns/100ps

module accessAlign (
  input  rvTypesPkg::funct3T  funct3,
  input  wbPkg::byteOffs      offset,
  input  rvTypesPkg::xlenWord storeData,
  output wbPkg::wbSel         sel,
  output wbPkg::wbData        datW,
  output logic                misaligned
);

  wbPkg::wbSel laneMask;  // lanes of the access size, starting at lane 0

  // size comes from funct3[1:0] for loads and stores alike
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        laneMask   = 8'b0000_0001;
        misaligned = 1'b0;             // bytes never misalign
        datW       = {8{storeData[7:0]}};
      end
      2'b01: begin
        laneMask   = 8'b0000_0011;
        misaligned = offset[0];
        datW       = {4{storeData[15:0]}};
      end
      2'b10: begin
        laneMask   = 8'b0000_1111;
        misaligned = |offset[1:0];
        datW       = {2{storeData[31:0]}};
      end
      default: begin
        laneMask   = 8'b1111_1111;
        misaligned = |offset;
        datW       = storeData;
      end
    endcase
  end

  // move the lane group up to the addressed byte
  // a misaligned offset may push lanes off the top but that request never runs
  assign sel = laneMask << offset;

endmodule

// File: busTimer.sv
`timescale 1ns/100ps
`include "lsuDefines.svh"

module busTimer (
  input  logic clk,
  input  logic rst,
  input  logic count,
  output logic expired
);

  localparam int cntW = $clog2(`BUS_TIMEOUT);

  logic [cntW-1:0] waitCnt;  // edges spent in the bus cycle so far

  // restarts from zero for every bus cycle
  always_ff @(posedge clk) begin
    if (rst || !count) begin
      waitCnt <= '0;
    end else begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  // high on the last allowed edge of the bus cycle
  assign expired = count && (waitCnt == cntW'(`BUS_TIMEOUT - 1));

endmodule

// File: loadChoose.sv
`timescale 1ns/100ps

module loadChoose (
  input  logic                clk,
  input  logic                rst,
  input  logic                capture,
  input  rvTypesPkg::funct3T  funct3,
  input  wbPkg::byteOffs      offset,
  input  wbPkg::wbData        datR,
  output rvTypesPkg::xlenWord loadData
);

  wbPkg::wbData        shifted;
  rvTypesPkg::xlenWord extended;

  // addressed byte down to lane 0
  assign shifted = datR >> {offset, 3'b000};

  always_comb begin
    case (funct3)
      rvTypesPkg::F3_B:  extended = {{56{shifted[7]}}, shifted[7:0]};
      rvTypesPkg::F3_BU: extended = {56'd0, shifted[7:0]};
      rvTypesPkg::F3_H:  extended = {{48{shifted[15]}}, shifted[15:0]};
      rvTypesPkg::F3_HU: extended = {48'd0, shifted[15:0]};
      rvTypesPkg::F3_W:  extended = {{32{shifted[31]}}, shifted[31:0]};
      rvTypesPkg::F3_WU: extended = {32'd0, shifted[31:0]};
      default:           extended = shifted;  // ld uses the full word
    endcase
  end

  // holds the value for the done cycle only
  always_ff @(posedge clk) begin
    if (rst || !capture) begin
      loadData <= '0;
    end else begin
      loadData <= extended;
    end
  end

endmodule

// File: loadStoreUnit.sv
`timescale 1ns/100ps

module loadStoreUnit (
  input  logic                clk,
  input  logic                rst,
  // core side
  input  logic                start,
  input  rvTypesPkg::opcodeT  opcode,
  input  rvTypesPkg::funct3T  funct3,
  input  rvTypesPkg::memAddr  addr,
  input  rvTypesPkg::xlenWord storeData,
  output logic                busy,
  output logic                done,
  output logic                fault,
  output rvTypesPkg::xlenWord loadData,
  // wishbone classic master
  output logic                wbCyc,
  output logic                wbStb,
  output logic                wbWe,
  output wbPkg::wbAddr        wbAdr,
  output wbPkg::wbSel         wbSel,
  output wbPkg::wbData        wbDatW,
  input  logic                wbAck,
  input  wbPkg::wbData        wbDatR
);

  rvTypesPkg::funct3T  reqFunct3;
  wbPkg::byteOffs      reqOffset;
  rvTypesPkg::xlenWord reqStoreData;
  wbPkg::wbSel         sel;
  wbPkg::wbData        datW;
  logic                misaligned;
  logic                timerCount;
  logic                expired;
  logic                capture;

  lsuControl control (
    .clk(clk), .rst(rst),
    .start(start), .opcode(opcode), .funct3(funct3), .addr(addr), .storeData(storeData),
    .misaligned(misaligned), .sel(sel), .datW(datW), .wbAck(wbAck), .expired(expired),
    .reqFunct3(reqFunct3), .reqOffset(reqOffset), .reqStoreData(reqStoreData),
    .timerCount(timerCount), .capture(capture),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
    .wbAdr(wbAdr), .wbSel(wbSel), .wbDatW(wbDatW),
    .busy(busy), .done(done), .fault(fault)
  );

  busTimer timer (
    .clk(clk), .rst(rst), .count(timerCount), .expired(expired)
  );

  accessAlign align (
    .funct3(reqFunct3), .offset(reqOffset), .storeData(reqStoreData),
    .sel(sel), .datW(datW), .misaligned(misaligned)
  );

  loadChoose choose (
    .clk(clk), .rst(rst), .capture(capture),
    .funct3(reqFunct3), .offset(reqOffset), .datR(wbDatR), .loadData(loadData)
  );

endmodule

// File: lsuControl.sv
`timescale 1ns/100ps
`include "lsuDefines.svh"

module lsuControl (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  rvTypesPkg::opcodeT  opcode,
  input  rvTypesPkg::funct3T  funct3,
  input  rvTypesPkg::memAddr  addr,
  input  rvTypesPkg::xlenWord storeData,
  input  logic                misaligned,
  input  wbPkg::wbSel         sel,
  input  wbPkg::wbData        datW,
  input  logic                wbAck,
  input  logic                expired,
  output rvTypesPkg::funct3T  reqFunct3,
  output wbPkg::byteOffs      reqOffset,
  output rvTypesPkg::xlenWord reqStoreData,
  output logic                timerCount,
  output logic                capture,
  output logic                wbCyc,
  output logic                wbStb,
  output logic                wbWe,
  output wbPkg::wbAddr        wbAdr,
  output wbPkg::wbSel         wbSel,
  output wbPkg::wbData        wbDatW,
  output logic                busy,
  output logic                done,
  output logic                fault
);

  wbPkg::lsuState      state;
  rvTypesPkg::funct3T  funct3Q;
  wbPkg::byteOffs      offsetQ;
  logic                isLoad;
  logic                isStore;
  logic                legal;

  // while idle the data modules see the live request, so the start edge can decide
  assign reqFunct3    = (state == wbPkg::IDLE) ? funct3 : funct3Q;
  assign reqOffset    = (state == wbPkg::IDLE) ? addr[`OFFS_W-1:0] : offsetQ;
  assign reqStoreData = storeData;  // placed data is only taken on the start edge

  assign isLoad  = (opcode == rvTypesPkg::OP_LOAD) && (funct3 != 3'b111);
  assign isStore = (opcode == rvTypesPkg::OP_STORE) && (funct3 < rvTypesPkg::F3_BU);  // sb..sd
  assign legal   = (isLoad || isStore) && !misaligned;

  assign busy       = (state != wbPkg::IDLE);
  assign done       = (state == wbPkg::DONE);
  assign timerCount = (state == wbPkg::BUS);
  assign capture    = (state == wbPkg::BUS) && wbAck && !wbWe;  // loads only

  // request latch and bus payload
  always_ff @(posedge clk) begin
    if ((state == wbPkg::IDLE) && start) begin
      funct3Q    <= funct3;
      offsetQ    <= addr[`OFFS_W-1:0];
      wbAdr      <= addr[`ADDR_W-1:`OFFS_W];
      wbSel      <= sel;
      wbDatW     <= datW;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wbPkg::IDLE;
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe  <= 1'b0;
      fault <= 1'b0;
    end else begin
      case (state)
        wbPkg::IDLE: begin
          if (start && legal) begin
            state <= wbPkg::BUS;
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe  <= isStore;
          end else if (start) begin
            state <= wbPkg::DONE;  // no bus cycle for a bad request
            fault <= 1'b1;
          end
        end
        wbPkg::BUS: begin
          // ack wins over a timeout on the same edge
          if (wbAck || expired) begin
            state <= wbPkg::DONE;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe  <= 1'b0;
            fault <= !wbAck;
          end
        end
        wbPkg::DONE: begin
          state <= wbPkg::IDLE;
          fault <= 1'b0;
        end
        default: state <= wbPkg::IDLE;
      endcase
    end
  end

endmodule

// File: lsuDefines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// register and bus data width
`define XLEN 64

// byte address width seen by the core
`define ADDR_W 32

// byte offset inside one doubleword
`define OFFS_W 3

// wait cycles allowed before a bus cycle is dropped
`define BUS_TIMEOUT 16

`endif

// File: rvTypesPkg.sv
`include "lsuDefines.svh"

package rvTypesPkg;

  typedef logic [`XLEN-1:0]   xlenWord;   // integer register value
  typedef logic [6:0]         opcodeT;
  typedef logic [2:0]         funct3T;
  typedef logic [`ADDR_W-1:0] memAddr;    // byte address

  // major opcodes of the memory instructions
  localparam opcodeT OP_LOAD  = 7'b0000011;
  localparam opcodeT OP_STORE = 7'b0100011;

  // funct3 access kinds
  // bit 2 picks zero extension, bits 1:0 the size
  localparam funct3T F3_B  = 3'b000;
  localparam funct3T F3_H  = 3'b001;
  localparam funct3T F3_W  = 3'b010;
  localparam funct3T F3_D  = 3'b011;
  localparam funct3T F3_BU = 3'b100;
  localparam funct3T F3_HU = 3'b101;
  localparam funct3T F3_WU = 3'b110;

endpackage

// File: tb.f
+incdir+.
rvTypesPkg.sv
wbPkg.sv
accessAlign.sv
loadChoose.sv
busTimer.sv
lsuControl.sv
loadStoreUnit.sv
tbWbMemory.sv
tbLoadStoreUnit.sv

// File: tbLoadStoreUnit.sv
`timescale 1ns/100ps
`include "lsuDefines.svh"

module tbLoadStoreUnit;

  localparam int memBytes  = 8192;
  localparam int maxCycles = 4000;  // ~130 requests at timeout length, with margin

  logic                clk;
  logic                rst;
  logic                start;
  rvTypesPkg::opcodeT  opcode;
  rvTypesPkg::funct3T  funct3;
  rvTypesPkg::memAddr  addr;
  rvTypesPkg::xlenWord storeData;
  logic                busy;
  logic                done;
  logic                fault;
  rvTypesPkg::xlenWord loadData;
  logic                wbCyc;
  logic                wbStb;
  logic                wbWe;
  wbPkg::wbAddr        wbAdr;
  wbPkg::wbSel         wbSel;
  wbPkg::wbData        wbDatW;
  logic                wbAck;
  wbPkg::wbData        wbDatR;
  logic [3:0]          waitStates;

  logic [7:0]          shadow [0:memBytes-1];  // expected memory bytes
  rvTypesPkg::xlenWord respData;
  logic                respFault;
  logic                respCyc;  // wbCyc seen during the request
  int                  cycles = 0;
  int                  seed;

  loadStoreUnit UUT (
    .clk(clk), .rst(rst),
    .start(start), .opcode(opcode), .funct3(funct3), .addr(addr), .storeData(storeData),
    .busy(busy), .done(done), .fault(fault), .loadData(loadData),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbSel(wbSel),
    .wbDatW(wbDatW), .wbAck(wbAck), .wbDatR(wbDatR)
  );

  tbWbMemory dataMem (
    .clk(clk), .rst(rst), .waitStates(waitStates),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbSel(wbSel),
    .wbDatW(wbDatW), .wbAck(wbAck), .wbDatR(wbDatR)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= maxCycles) begin
      $display("Error at %0t ns: the tests did not finish within %0d cycles", $time, maxCycles);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // mixes every address bit into the byte
  function automatic logic [7:0] fillByte(input int a);
    logic [15:0] mix;
    mix = 16'(a) * 16'd157 + 16'(a >> 7);
    return mix[11:4] ^ 8'h5a;
  endfunction

  // little endian gather from the shadow, then extension by funct3
  function automatic rvTypesPkg::xlenWord expectLoad(input rvTypesPkg::funct3T f3, input int a);
    int size;
    int i;
    rvTypesPkg::xlenWord val;
    size = 1 << f3[1:0];
    val  = '0;
    for (i = 0; i < size; i++) begin
      val[8*i +: 8] = shadow[a + i];
    end
    if (!f3[2] && size < 8 && val[8*size-1]) begin
      for (i = 8 * size; i < 64; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  task automatic writeShadow(input rvTypesPkg::funct3T f3, input int a,
                             input rvTypesPkg::xlenWord data);
    int i;
    for (i = 0; i < (1 << f3[1:0]); i++) begin
      shadow[a + i] = data[8*i +: 8];
    end
  endtask

  task automatic fillMemory();
    int a;
    for (a = 0; a < memBytes; a++) begin
      shadow[a] = fillByte(a);
      dataMem.ram[a / 8][8*(a % 8) +: 8] = shadow[a];
    end
  endtask

  task automatic checkMemoryIntact();
    int w;
    for (w = 0; w < memBytes / 8; w++) begin
      checkValue($sformatf("ram[%0d]", w), dataMem.ram[w], expectLoad(rvTypesPkg::F3_D, 8 * w));
    end
  endtask

  // one request from start to the cycle after done
  task automatic issueRequest(input rvTypesPkg::opcodeT op, input rvTypesPkg::funct3T f3,
                              input int a, input rvTypesPkg::xlenWord sd);
    @(posedge clk);
    #1;
    checkValue("busy", busy, 1'b0);
    start     = 1'b1;
    opcode    = op;
    funct3    = f3;
    addr      = rvTypesPkg::memAddr'(a);
    storeData = sd;
    respCyc   = 1'b0;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (!done) begin
      checkValue("busy", busy, 1'b1);
      if (wbCyc) respCyc = 1'b1;
      @(posedge clk);
      #1;
    end
    checkValue("busy", busy, 1'b1);    // still busy in the done cycle
    checkValue("wbCyc", wbCyc, 1'b0);  // bus cycle already closed
    checkValue("wbStb", wbStb, 1'b0);
    respData  = loadData;
    respFault = fault;
    @(posedge clk);
    #1;
    checkValue("done", done, 1'b0);  // single cycle pulse
  endtask

  task automatic checkFaultNoBus();
    checkValue("fault", respFault, 1'b1);
    checkValue("loadData", respData, '0);
    checkValue("wbCyc seen", respCyc, 1'b0);
  endtask

  task automatic idleAfterReset();
    checkValue("busy", busy, 1'b0);
    checkValue("done", done, 1'b0);
    checkValue("fault", fault, 1'b0);
    checkValue("wbCyc", wbCyc, 1'b0);
    checkValue("wbStb", wbStb, 1'b0);
    checkValue("wbWe", wbWe, 1'b0);
  endtask

  // every width at every aligned offset, read back as a doubleword
  task automatic storeAllWidths();
    int f3;
    int offs;
    int base;
    rvTypesPkg::xlenWord data;
    for (f3 = 0; f3 < 4; f3++) begin
      for (offs = 0; offs < 8; offs += (1 << f3)) begin
        base = 8 * (256 + ($urandom % 256));
        data = {$urandom, $urandom};
        issueRequest(rvTypesPkg::OP_STORE, rvTypesPkg::funct3T'(f3), base + offs, data);
        checkValue("fault", respFault, 1'b0);
        checkValue("loadData", respData, '0);
        writeShadow(rvTypesPkg::funct3T'(f3), base + offs, data);
        issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::F3_D, base, '0);
        checkValue("fault", respFault, 1'b0);
        checkValue("loadData", respData, expectLoad(rvTypesPkg::F3_D, base));
      end
    end
  endtask

  task automatic loadAllKinds(input int waits);
    int f3;
    int offs;
    int base;
    waitStates = 4'(waits);
    for (f3 = 0; f3 < 7; f3++) begin
      base = 8 * ($urandom % 1024);
      for (offs = 0; offs < 8; offs += (1 << f3[1:0])) begin
        issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::funct3T'(f3), base + offs,
                     {$urandom, $urandom});
        checkValue("fault", respFault, 1'b0);
        checkValue("loadData", respData, expectLoad(rvTypesPkg::funct3T'(f3), base + offs));
      end
    end
  endtask

  task automatic misalignedFaults();
    issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::F3_H, 16'h0801, '0);
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::F3_HU, 16'h0813, '0);
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::F3_W, 16'h0822, '0);
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::F3_WU, 16'h0835, '0);
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::F3_D, 16'h0844, '0);
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_STORE, rvTypesPkg::F3_H, 16'h0851, {$urandom, $urandom});
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_STORE, rvTypesPkg::F3_W, 16'h0866, {$urandom, $urandom});
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_STORE, rvTypesPkg::F3_D, 16'h0873, {$urandom, $urandom});
    checkFaultNoBus();
    checkMemoryIntact();
  endtask

  task automatic illegalFaults();
    issueRequest(7'b0110011, rvTypesPkg::F3_W, 16'h0900, '0);  // register op
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_LOAD, 3'b111, 16'h0908, '0);
    checkFaultNoBus();
    issueRequest(rvTypesPkg::OP_STORE, rvTypesPkg::F3_BU, 16'h0910, {$urandom, $urandom});
    checkFaultNoBus();
    checkMemoryIntact();
  endtask

  // the bus timer has to end these
  task automatic silentRegionTimeout();
    issueRequest(rvTypesPkg::OP_LOAD, rvTypesPkg::F3_D, 32'h0001_0000, '0);
    checkValue("fault", respFault, 1'b1);
    checkValue("loadData", respData, '0);
    checkValue("wbCyc seen", respCyc, 1'b1);
    issueRequest(rvTypesPkg::OP_STORE, rvTypesPkg::F3_D, 32'h0001_0008, {$urandom, $urandom});
    checkValue("fault", respFault, 1'b1);
    checkValue("wbCyc seen", respCyc, 1'b1);
    checkMemoryIntact();
  endtask

  initial begin
    seed       = $urandom(8);
    rst        = 1'b1;
    start      = 1'b0;
    opcode     = '0;
    funct3     = '0;
    addr       = '0;
    storeData  = '0;
    waitStates = '0;
    fillMemory();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    idleAfterReset();
    storeAllWidths();
    loadAllKinds(0);
    loadAllKinds(1);
    loadAllKinds(3);
    misalignedFaults();
    illegalFaults();
    silentRegionTimeout();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: tbWbMemory.sv
`timescale 1ns/100ps

module tbWbMemory (
  input  logic         clk,
  input  logic         rst,
  input  logic [3:0]   waitStates,  // edges between strobe and ack
  input  logic         wbCyc,
  input  logic         wbStb,
  input  logic         wbWe,
  input  wbPkg::wbAddr wbAdr,
  input  wbPkg::wbSel  wbSel,
  input  wbPkg::wbData wbDatW,
  output logic         wbAck,
  output wbPkg::wbData wbDatR
);

  localparam int words = 1024;  // 8 KB of doublewords
  localparam logic [31:0] silentBase = 32'h0001_0000;

  logic [63:0] ram [0:words-1];
  logic [3:0]  waitCnt;
  logic        silent;
  logic [9:0]  index;

  // nothing answers at or above the silent base
  assign silent = ({wbAdr, 3'b000} >= silentBase);
  assign index  = wbAdr[9:0];

  // registered ack after the programmed wait states
  always @(posedge clk) begin
    if (rst) begin
      wbAck   <= 1'b0;
      wbDatR  <= '0;
      waitCnt <= '0;
    end else if (wbCyc && wbStb && !wbAck && !silent) begin
      if (waitCnt == waitStates) begin
        wbAck   <= 1'b1;
        waitCnt <= '0;
        if (wbWe) begin
          for (int lane = 0; lane < 8; lane++) begin
            if (wbSel[lane]) begin
              ram[index][8*lane +: 8] = wbDatW[8*lane +: 8];
            end
          end
        end else begin
          wbDatR <= ram[index];
        end
      end else begin
        waitCnt <= waitCnt + 1'b1;
      end
    end else begin
      wbAck   <= 1'b0;  // one ack per cycle
      waitCnt <= '0;
    end
  end

endmodule

// File: wbPkg.sv
`include "lsuDefines.svh"

package wbPkg;

  typedef logic [`XLEN-1:0]          wbData;   // one bus data word
  typedef logic [`ADDR_W-`OFFS_W-1:0] wbAddr;  // doubleword address
  typedef logic [`XLEN/8-1:0]        wbSel;    // one bit per byte lane
  typedef logic [`OFFS_W-1:0]        byteOffs;

  // load/store control
  typedef enum logic [1:0] {
    IDLE,  // waiting for start
    BUS,   // wishbone cycle open
    DONE   // result cycle
  } lsuState;

endpackage
